// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = viterbiFrontEndTb
FILELIST  = all.f
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== all.f ====
+incdir+verilog
verilog/viterbiPkg.sv
verilog/symbolSlicer.sv
verilog/codePairMapper.sv
verilog/syncSearchFsm.sv
verilog/sprtSyncDetector.sv
verilog/wbModeRegs.sv
verilog/viterbiFrontEnd.sv
verification/viterbiFrontEnd_asserts.sv
verification/viterbiFrontEndTb.sv

// ==== verification/viterbiFrontEndTb.sv ====
`include "viterbi_cfg.svh"

module viterbiFrontEndTb import viterbiPkg::*; ();

    logic clk, reset, symEn, wbCyc, wbStb, wbWe, wbAck, pairValid, decoderClear, inSync;
    symSample_t iSym, qSym;
    wbAddr_t wbAddr;
    wbData_t wbDatIn, wbDatOut;
    codePair_t pair;
    berReport_t berReport;
    hypothesis_t hypothesis;

    logic [31:0] lfsr = 32'h8e610d54;
    int errorCount = 0;
    int checkCount = 0;

    // Reference model state
    demodMode_t mMode;
    int mHyp, mAccum;
    logic mPhase, mInSync;
    softSym_t mCurI, mCurQ, mPrevI, mPrevQ;

    viterbiFrontEnd viterbiFrontEnd_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextBits(input int n);
        logic [31:0] v;
        logic fb;
        int b;
        v = '0;
        for (b = 0; b < n; b++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic softSym_t hardSlice(input symSample_t s);
        return (s < 0) ? `SOFT_ZERO : `SOFT_ONE;
    endfunction

    task automatic checkValue(input bit ok, input string what);
        checkCount++;
        assert (ok) else begin
            errorCount++;
            $display("mismatch at %0t: %s", $time, what);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("timeout at %0t: %s did not happen in time", $time, what);
    endtask

    // Expected pair from the mapping table
    function automatic codePair_t expectedPair(output logic take);
        softSym_t q1, g1, g2;
        q1 = (mMode == MODE_OQPSK) ? mPrevQ : mCurQ;
        take = 1'b1;
        if (mMode == MODE_QPSK || mMode == MODE_OQPSK) begin
            case (mHyp)
                0: begin
                    g1 = mCurI;
                    g2 = mCurQ;
                end
                1: begin
                    g1 = q1;
                    g2 = ~mCurI;
                end
                2: begin
                    g1 = ~mCurI;
                    g2 = ~mCurQ;
                end
                3: begin
                    g1 = ~q1;
                    g2 = mCurI;
                end
                4: begin
                    g1 = mCurI;
                    g2 = ~mCurQ;
                end
                5: begin
                    g1 = q1;
                    g2 = mCurI;
                end
                6: begin
                    g1 = ~mCurI;
                    g2 = mCurQ;
                end
                default: begin
                    g1 = ~q1;
                    g2 = ~mCurI;
                end
            endcase
        end else begin
            g1 = mPrevI;
            g2 = mCurI;
            take = (mHyp % 2 == 0) ? mPhase : ~mPhase;
            if (mMode == MODE_BPSK) begin
                if (mHyp == 2 || mHyp == 3 || mHyp == 6 || mHyp == 7) begin
                    g1 = ~g1;
                    g2 = ~g2;
                end
                if (mHyp >= 4) g2 = ~g2;
            end else if (mHyp >= 2) begin
                g2 = ~g2;
            end
        end
        return '{g1: g1, g2: g2};
    endfunction

    task automatic sendSymbol();
        codePair_t expPair;
        logic expTake, seen;
        int k;
        iSym = symSample_t'(nextBits(18));
        qSym = symSample_t'(nextBits(18));
        if (mMode == MODE_BPSK || mMode == MODE_SINGLE_RAIL) mPhase = ~mPhase;
        mPrevI = mCurI;
        mPrevQ = mCurQ;
        mCurI = hardSlice(iSym);
        mCurQ = hardSlice(qSym);
        expPair = expectedPair(expTake);
        symEn = 1'b1;
        @(negedge clk);
        symEn = 1'b0;
        seen = 1'b0;
        k = 0;
        while (!seen && k < 4) begin
            @(negedge clk);
            k++;
            if (pairValid) seen = 1'b1;
        end
        if (expTake) begin
            if (!seen) begin
                reportTimeout("pairValid");
            end else begin
                checkValue(pair == expPair,
                           $sformatf("pair %h, expected %h (mode %0d hyp %0d)",
                                     pair, expPair, mMode, mHyp));
            end
        end else begin
            checkValue(!seen, "pairValid on a symbol that takes no pair");
        end
        repeat (nextBits(2)) @(negedge clk);
    endtask

    task automatic wbAccess(input logic we, input wbAddr_t addr, input wbData_t data,
                            output wbData_t rdata);
        logic got;
        int k;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAddr = addr;
        wbDatIn = data;
        got = 1'b0;
        k = 0;
        rdata = '0;
        while (!got && k < 8) begin
            @(negedge clk);
            k++;
            if (wbAck) begin
                got = 1'b1;
                rdata = wbDatOut;
            end
        end
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        if (!got) reportTimeout("wbAck");
        @(negedge clk);
    endtask

    task automatic writeMode(input demodMode_t m);
        wbData_t unused;
        wbAccess(1'b1, `REG_MODE, {30'd0, m}, unused);
        mMode = m;
        mHyp = 0;
        if (m == MODE_QPSK || m == MODE_OQPSK) mPhase = 1'b1;
    endtask

    task automatic checkMode();
        wbData_t rd;
        wbAccess(1'b0, `REG_MODE, '0, rd);
        checkValue(rd == {30'd0, mMode},
                   $sformatf("mode readback %h, expected mode %0d", rd, mMode));
    endtask

    task automatic checkStatus();
        wbData_t rd;
        wbAccess(1'b0, `REG_STATUS, '0, rd);
        checkValue(rd == {25'd0, 3'(mHyp), 3'd0, mInSync},
                   $sformatf("status %h, expected hyp %0d inSync %0b", rd, mHyp, mInSync));
    endtask

    task automatic sendReport(input berCount_t count, output logic expClear);
        expClear = 1'b0;
        if (count == 0) begin
            if (mAccum >= int'(`SPRT_SYNC_LIMIT - `SPRT_STEP)) begin
                mAccum = `SPRT_SYNC_LIMIT;
                mInSync = 1'b1;
            end else begin
                mAccum += `SPRT_STEP;
            end
        end else if (int'(count) <= mAccum) begin
            mAccum -= count;
        end else begin
            mAccum = `SPRT_START_VALUE;
            mInSync = 1'b0;
            expClear = 1'b1;
            mHyp = (mMode == MODE_SINGLE_RAIL) ? (mHyp + 1) % 4 : (mHyp + 1) % 8;
        end
        berReport = '{done: 1'b1, count: count};
        @(negedge clk);
        berReport = '0;
        checkValue(inSync == mInSync, $sformatf("inSync %0b, expected %0b", inSync, mInSync));
        checkValue(decoderClear == expClear,
                   $sformatf("decoderClear %0b, expected %0b", decoderClear, expClear));
        @(negedge clk);
        checkValue(hypothesis == hypothesis_t'(mHyp),
                   $sformatf("hypothesis %0d, expected %0d", hypothesis, mHyp));
    endtask

    initial begin
        logic cleared;
        int n, step, m;
        demodMode_t modes[3];
        modes[0] = MODE_BPSK;
        modes[1] = MODE_OQPSK;
        modes[2] = MODE_SINGLE_RAIL;
        reset = 1'b1;
        symEn = 1'b0;
        iSym = '0;
        qSym = '0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAddr = '0;
        wbDatIn = '0;
        berReport = '0;
        mMode = MODE_QPSK;
        mHyp = 0;
        mAccum = `SPRT_START_VALUE;
        mPhase = 1'b1;
        mInSync = 1'b0;
        mCurI = `SOFT_ONE;
        mCurQ = `SOFT_ONE;
        mPrevI = `SOFT_ONE;
        mPrevQ = `SOFT_ONE;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        checkValue(!pairValid && !decoderClear && !inSync && !wbAck, "outputs not idle after reset");

        repeat (20) sendSymbol();
        checkStatus();
        checkMode();
        writeMode(MODE_OQPSK);
        checkMode();
        writeMode(MODE_QPSK);
        checkMode();

        // Clean reports up to sync
        n = 0;
        while (!mInSync && n < 40) begin
            sendReport('0, cleared);
            n++;
        end
        if (!mInSync) reportTimeout("inSync");
        checkStatus();

        // Random error counts until sync is lost
        cleared = 1'b0;
        n = 0;
        while (!cleared && n < 100) begin
            sendReport(berCount_t'(nextBits(5)) + 16'd1, cleared);
            n++;
        end
        if (!cleared) reportTimeout("outOfSync");
        repeat (10) sendSymbol();
        checkStatus();

        // Walk every hypothesis through its wrap in the other modes
        for (m = 0; m < 3; m++) begin
            writeMode(modes[m]);
            for (step = 0; step < ((modes[m] == MODE_SINGLE_RAIL) ? 5 : 9); step++) begin
                repeat (10) sendSymbol();
                sendReport(16'hffff, cleared);
            end
            checkStatus();
        end

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (200000) @(posedge clk);
        $display("timeout: the simulation did not finish");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== verification/viterbiFrontEnd_asserts.sv ====
module viterbiFrontEnd_asserts (
    input logic clk,
    input logic reset,
    input logic wbCyc,
    input logic wbStb,
    input logic wbAck,
    input logic decoderClear,
    input logic symEn,
    input logic pairValid
);

    ackOneCycle: assert property (@(posedge clk) disable iff (reset) wbAck |=> !wbAck)
        else $error("wbAck stayed high for more than one cycle");

    ackFollowsRequest: assert property (@(posedge clk) disable iff (reset)
        wbAck |-> $past(wbCyc && wbStb))
        else $error("wbAck without a preceding cyc and stb");

    clearOneCycle: assert property (@(posedge clk) disable iff (reset)
        decoderClear |=> !decoderClear)
        else $error("outOfSync pulse longer than one cycle");

    // Pair latency is fixed at two cycles
    pairLatency: assert property (@(posedge clk) disable iff (reset)
        pairValid |-> $past(symEn, 2))
        else $error("pairValid not two cycles after symEn");

endmodule

bind viterbiFrontEnd viterbiFrontEnd_asserts viterbiFrontEnd_asserts_i (
    .clk(clk),
    .reset(reset),
    .wbCyc(wbCyc),
    .wbStb(wbStb),
    .wbAck(wbAck),
    .decoderClear(decoderClear),
    .symEn(symEn),
    .pairValid(pairValid)
);

// ==== verilog/codePairMapper.sv ====
module codePairMapper import viterbiPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        softValid,
    input  logic        pairPhase,
    input  softPair_t   cur,
    input  softPair_t   prev,
    input  demodMode_t  mode,
    input  hypothesis_t hypothesis,
    output codePair_t   pair,
    output logic        pairValid
);

    softSym_t  qFirst;
    codePair_t nextPair;
    logic      take;

    always_comb begin
        // OQPSK offsets Q by half a symbol, so g1 uses the delayed Q
        qFirst = (mode == MODE_OQPSK) ? prev.qSoft : cur.qSoft;
        nextPair = '{g1: prev.iSoft, g2: cur.iSoft};
        take = pairPhase;
        case (mode)
            MODE_QPSK, MODE_OQPSK: begin
                case (hypothesis)
                    HYP_P0: begin
                        nextPair = '{g1: cur.iSoft, g2: cur.qSoft};
                    end
                    HYP_P90: begin
                        nextPair = '{g1: qFirst, g2: ~cur.iSoft};
                    end
                    HYP_P180: begin
                        nextPair = '{g1: ~cur.iSoft, g2: ~cur.qSoft};
                    end
                    HYP_P270: begin
                        nextPair = '{g1: ~qFirst, g2: cur.iSoft};
                    end
                    HYP_P0_INV: begin
                        nextPair = '{g1: cur.iSoft, g2: ~cur.qSoft};
                    end
                    HYP_P90_INV: begin
                        nextPair = '{g1: qFirst, g2: cur.iSoft};
                    end
                    HYP_P180_INV: begin
                        nextPair = '{g1: ~cur.iSoft, g2: cur.qSoft};
                    end
                    default: begin
                        nextPair = '{g1: ~qFirst, g2: ~cur.iSoft};
                    end
                endcase
            end
            MODE_BPSK: begin
                // Shifted hypotheses pair on the other phase
                take = pairPhase ^ hypothesis[0];
                if (hypothesis[1]) begin
                    nextPair.g1 = ~nextPair.g1;
                    nextPair.g2 = ~nextPair.g2;
                end
                if (hypothesis[2]) begin
                    nextPair.g2 = ~nextPair.g2;
                end
            end
            default: begin
                // Single rail has no phase ambiguity
                take = pairPhase ^ hypothesis[0];
                if (hypothesis[1]) begin
                    nextPair.g2 = ~nextPair.g2;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pairValid <= 1'b0;
        end else begin
            pairValid <= softValid & take;
        end
    end

    always_ff @(posedge clk) begin
        if (softValid && take) begin
            pair <= nextPair;
        end
    end

endmodule

// ==== verilog/sprtSyncDetector.sv ====
`include "viterbi_cfg.svh"

module sprtSyncDetector import viterbiPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  berReport_t berReport,
    output logic       inSync,
    output logic       outOfSync
);

    sprtAccum_t sprtAccum;
    logic       atLimit;
    logic       drained;

    // Accumulator stays between zero and the limit
    assign atLimit = sprtAccum >= sprtAccum_t'(`SPRT_SYNC_LIMIT - `SPRT_STEP);
    assign drained = berReport.count > berCount_t'(sprtAccum);

    always_ff @(posedge clk) begin
        if (reset) begin
            sprtAccum <= sprtAccum_t'(`SPRT_START_VALUE);
            inSync <= 1'b0;
            outOfSync <= 1'b0;
        end else begin
            outOfSync <= 1'b0;
            if (berReport.done) begin
                if (berReport.count == '0) begin
                    if (atLimit) begin
                        sprtAccum <= sprtAccum_t'(`SPRT_SYNC_LIMIT);
                        inSync <= 1'b1;
                    end else begin
                        sprtAccum <= sprtAccum + sprtAccum_t'(`SPRT_STEP);
                    end
                end else if (!drained) begin
                    sprtAccum <= sprtAccum - sprtAccum_t'(berReport.count);
                end else begin
                    // Lost sync so the test restarts
                    sprtAccum <= sprtAccum_t'(`SPRT_START_VALUE);
                    inSync <= 1'b0;
                    outOfSync <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/symbolSlicer.sv ====
`include "viterbi_cfg.svh"

module symbolSlicer import viterbiPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       symEn,
    input  demodMode_t mode,
    input  symSample_t iSym,
    input  symSample_t qSym,
    output softPair_t  cur,
    output softPair_t  prev,
    output logic       softValid,
    output logic       pairPhase
);

    function automatic softSym_t slice(input symSample_t sample);
        if (sample[17]) begin
            return `SOFT_ZERO;
        end
        return `SOFT_ONE;
    endfunction

    // One symbol delay line
    always_ff @(posedge clk) begin
        if (symEn) begin
            cur.iSoft <= slice(iSym);
            cur.qSoft <= slice(qSym);
            prev <= cur;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            softValid <= 1'b0;
            pairPhase <= 1'b0;
        end else begin
            softValid <= symEn;
            // Dual rail modes take a pair on every symbol
            if (mode == MODE_QPSK || mode == MODE_OQPSK) begin
                pairPhase <= 1'b1;
            end else if (symEn) begin
                pairPhase <= ~pairPhase;
            end
        end
    end

endmodule

// ==== verilog/syncSearchFsm.sv ====
module syncSearchFsm import viterbiPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        outOfSync,
    input  logic        modeLoad,
    input  demodMode_t  mode,
    output hypothesis_t hypothesis
);

    hypothesis_t hypNext;

    always_comb begin
        hypNext = hypothesis;
        if (modeLoad) begin
            hypNext = HYP_P0;
        end else if (outOfSync) begin
            case (hypothesis)
                HYP_P0:       hypNext = HYP_P90;
                HYP_P90:      hypNext = HYP_P180;
                HYP_P180:     hypNext = HYP_P270;
                // Single rail only searches the first four
                HYP_P270: begin
                    if (mode == MODE_SINGLE_RAIL) begin
                        hypNext = HYP_P0;
                    end else begin
                        hypNext = HYP_P0_INV;
                    end
                end
                HYP_P0_INV:   hypNext = HYP_P90_INV;
                HYP_P90_INV:  hypNext = HYP_P180_INV;
                HYP_P180_INV: hypNext = HYP_P270_INV;
                default:      hypNext = HYP_P0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hypothesis <= HYP_P0;
        end else begin
            hypothesis <= hypNext;
        end
    end

endmodule

// ==== verilog/viterbiFrontEnd.sv ====
module viterbiFrontEnd import viterbiPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        symEn,
    input  symSample_t  iSym,
    input  symSample_t  qSym,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  wbAddr_t     wbAddr,
    input  wbData_t     wbDatIn,
    output wbData_t     wbDatOut,
    output logic        wbAck,
    output codePair_t   pair,
    output logic        pairValid,
    input  berReport_t  berReport,
    output logic        decoderClear,
    output logic        inSync,
    output hypothesis_t hypothesis
);

    demodMode_t mode;
    logic       modeLoad;
    softPair_t  cur;
    softPair_t  prev;
    logic       softValid;
    logic       pairPhase;

    symbolSlicer symbolSlicer_i (
        .clk(clk),
        .reset(reset),
        .symEn(symEn),
        .mode(mode),
        .iSym(iSym),
        .qSym(qSym),
        .cur(cur),
        .prev(prev),
        .softValid(softValid),
        .pairPhase(pairPhase)
    );

    codePairMapper codePairMapper_i (
        .clk(clk),
        .reset(reset),
        .softValid(softValid),
        .pairPhase(pairPhase),
        .cur(cur),
        .prev(prev),
        .mode(mode),
        .hypothesis(hypothesis),
        .pair(pair),
        .pairValid(pairValid)
    );

    // Loss of sync also clears the external decoder
    syncSearchFsm syncSearchFsm_i (
        .clk(clk),
        .reset(reset),
        .outOfSync(decoderClear),
        .modeLoad(modeLoad),
        .mode(mode),
        .hypothesis(hypothesis)
    );

    sprtSyncDetector sprtSyncDetector_i (
        .clk(clk),
        .reset(reset),
        .berReport(berReport),
        .inSync(inSync),
        .outOfSync(decoderClear)
    );

    wbModeRegs wbModeRegs_i (
        .clk(clk),
        .reset(reset),
        .wbCyc(wbCyc),
        .wbStb(wbStb),
        .wbWe(wbWe),
        .wbAddr(wbAddr),
        .wbDatIn(wbDatIn),
        .wbDatOut(wbDatOut),
        .wbAck(wbAck),
        .inSync(inSync),
        .hypothesis(hypothesis),
        .mode(mode),
        .modeLoad(modeLoad)
    );

endmodule

// ==== verilog/viterbiPkg.sv ====
package viterbiPkg;

    typedef logic signed [17:0] symSample_t;
    typedef logic        [2:0]  softSym_t;
    typedef logic        [15:0] berCount_t;
    typedef logic signed [15:0] sprtAccum_t;
    typedef logic        [1:0]  wbAddr_t;
    typedef logic        [31:0] wbData_t;

    typedef enum logic [1:0] {
        MODE_BPSK        = 2'd0,
        MODE_QPSK        = 2'd1,
        MODE_OQPSK       = 2'd2,
        MODE_SINGLE_RAIL = 2'd3
    } demodMode_t;

    // Search order; in BPSK bit 0 selects shifted pairing and bit 1 the 180 phase,
    // in single-rail bit 1 selects G2 inversion
    typedef enum logic [2:0] {
        HYP_P0       = 3'd0,
        HYP_P90      = 3'd1,
        HYP_P180     = 3'd2,
        HYP_P270     = 3'd3,
        HYP_P0_INV   = 3'd4,
        HYP_P90_INV  = 3'd5,
        HYP_P180_INV = 3'd6,
        HYP_P270_INV = 3'd7
    } hypothesis_t;

    typedef struct packed {
        softSym_t iSoft;
        softSym_t qSoft;
    } softPair_t;

    typedef struct packed {
        softSym_t g1;
        softSym_t g2;
    } codePair_t;

    typedef struct packed {
        logic      done;
        berCount_t count;
    } berReport_t;

endpackage

// ==== verilog/viterbi_cfg.svh ====
`ifndef VITERBI_CFG_SVH
`define VITERBI_CFG_SVH

// SPRT sync detector
`define SPRT_SYNC_LIMIT     16'd128
`define SPRT_START_VALUE    16'd64
`define SPRT_STEP           16'd8

// Hard decision soft levels
`define SOFT_ZERO           3'b010
`define SOFT_ONE            3'b101

// Wishbone register word offsets
`define REG_MODE            2'd0
`define REG_STATUS          2'd1

`endif

// ==== verilog/wbModeRegs.sv ====
`include "viterbi_cfg.svh"

module wbModeRegs import viterbiPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wbCyc,
    input  logic        wbStb,
    input  logic        wbWe,
    input  wbAddr_t     wbAddr,
    input  wbData_t     wbDatIn,
    output wbData_t     wbDatOut,
    output logic        wbAck,
    input  logic        inSync,
    input  hypothesis_t hypothesis,
    output demodMode_t  mode,
    output logic        modeLoad
);

    logic access;

    // No new access while acking the current one
    assign access = wbCyc & wbStb & ~wbAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
            mode <= MODE_QPSK;
            modeLoad <= 1'b0;
        end else begin
            wbAck <= access;
            modeLoad <= 1'b0;
            if (access && wbWe && wbAddr == `REG_MODE) begin
                mode <= demodMode_t'(wbDatIn[1:0]);
                modeLoad <= 1'b1;
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk) begin
        if (access) begin
            case (wbAddr)
                `REG_MODE: begin
                    wbDatOut <= {30'd0, mode};
                end
                `REG_STATUS: begin
                    wbDatOut <= {25'd0, hypothesis, 3'd0, inSync};
                end
                default: begin
                    wbDatOut <= '0;
                end
            endcase
        end
    end

endmodule
